//--- compile.f
logic/icache_pkg.sv
logic/icache_beat_counter.sv
logic/icache_tag_store.sv
logic/icache_hit_detect.sv
logic/icache_data_store.sv
logic/icache_ctrl_fsm.sv
logic/icache_top.sv
sim/icache_tb.sv

//--- Makefile
TOP = icache_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -o V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '** PASS **' > /dev/null

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- sim/icache_tb.sv
// ==============================
// Instruction cache testbench
// Drives fetches against a memory model and checks every response
// against a reference cache model
// ==============================

`timescale 1ns/10ps

module icache_tb;

	// About 450 fetches, a miss with the slowest memory costs about 25 cycles
	localparam int max_cycles = 12000;

	logic clk = 1'b0;
	logic arst_n;
	logic flush;
	logic req_valid;
	logic req_ready;
	icache_pkg::icache_addr_u req_addr;
	logic rsp_valid;
	logic rsp_ready;
	icache_pkg::fetch_rsp_t rsp;
	logic mem_req_valid;
	logic mem_req_ready;
	icache_pkg::mem_req_t mem_req;
	logic mem_rsp_valid;
	logic mem_rsp_ready;
	logic [31:0] mem_rsp_data;

	integer seed = 32'h1bb6ebe5;

	// Expectation for the one fetch in flight
	logic [15:0] exp_addr;
	logic [31:0] exp_word;
	bit exp_hit;

	// Random rsp_ready stretches when set
	bit stall_mode;

	// Reference cache state
	logic [7:0] m_tag [16][4];
	bit m_valid [16][4];
	logic [1:0] m_rr [16];

	// Check bookkeeping
	int value_errs = 0;
	int proto_errs = 0;
	int stim_errs = 0;
	int rsp_count = 0;
	int edge_count = 0;
	int accept_edge = 0;
	int mem_reqs = 0;
	int cycle = 0;
	bit rsp_seen = 1'b0;
	icache_pkg::fetch_rsp_t held_rsp;

	icache_top icache_top_i (
		.clk(clk),
		.arst_n(arst_n),
		.flush(flush),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_addr(req_addr),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp(rsp),
		.mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.mem_req(mem_req),
		.mem_rsp_valid(mem_rsp_valid),
		.mem_rsp_ready(mem_rsp_ready),
		.mem_rsp_data(mem_rsp_data)
	);

	always #2 clk = ~clk;

	// ==============================
	// Reference model
	// ==============================

	// Memory content is a fixed mix of the word address, byte offset ignored
	function automatic logic [31:0] expected_word(input logic [15:0] a);
		logic [13:0] wa;
		wa = a[15:2];
		return {wa, 2'b10, wa ^ 14'h15a3, 2'b01};
	endfunction

	// Looks the address up and fills the line on a miss, like the cache would
	// Lowest invalid way first, else the round-robin pointer of the set
	task automatic predict_lookup(input logic [15:0] a, output bit hit);
		logic [3:0] idx;
		logic [1:0] way;
		idx = a[7:4];
		hit = 1'b0;
		for (int w = 0; w < 4; w++)
		begin
			if (m_valid[idx][w] && m_tag[idx][w] == a[15:8])
				hit = 1'b1;
		end
		if (!hit)
		begin
			way = m_rr[idx];
			for (int w = 3; w >= 0; w--)
			begin
				if (!m_valid[idx][w])
					way = 2'(w);
			end
			m_tag[idx][way] = a[15:8];
			m_valid[idx][way] = 1'b1;
			m_rr[idx] = way + 2'd1;
		end
	endtask

	// ==============================
	// Stimulus
	// ==============================

	// One fetch from acceptance to response, entered and left on a falling edge
	task automatic fetch(input logic [15:0] a);
		bit hit;
		int done_before;
		predict_lookup(a, hit);
		exp_addr = a;
		exp_hit = hit;
		exp_word = expected_word(a);
		done_before = rsp_count;
		req_addr.raw = a;
		req_valid = 1'b1;
		do
			@(posedge clk);
		while (!req_ready);
		@(negedge clk);
		req_valid = 1'b0;
		req_addr.raw = 16'h0;
		while (rsp_count == done_before)
			@(negedge clk);
	endtask

	// One-cycle flush pulse while the cache sits idle
	task automatic flush_lines();
		assert (req_ready)
		else
		begin
			stim_errs++;
			$display("Cache was not idle when the flush was applied");
		end
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		for (int s = 0; s < 16; s++)
		begin
			for (int w = 0; w < 4; w++)
				m_valid[s][w] = 1'b0;
		end
	endtask

	initial
	begin
		arst_n = 1'b0;
		flush = 1'b0;
		req_valid = 1'b0;
		req_addr.raw = 16'h0;
		stall_mode = 1'b0;
		for (int s = 0; s < 16; s++)
		begin
			m_rr[s] = 2'd0;
			for (int w = 0; w < 4; w++)
				m_valid[s][w] = 1'b0;
		end
		repeat (16) @(posedge clk);
		assert (!rsp_valid && !mem_req_valid && !mem_rsp_ready)
		else
		begin
			stim_errs++;
			$display("Response or memory handshake active during reset");
		end
		@(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		assert (req_ready)
		else
		begin
			stim_errs++;
			$display("req_ready stayed low after reset");
		end

		// Cold miss, then the rest of the line hits
		fetch(16'h1234);
		fetch(16'h1238);
		fetch(16'h123c);
		fetch(16'h1230);

		// Five tags in set 5 fill ways 0 to 3 and then evict round-robin
		for (int t = 0; t < 5; t++)
			fetch({8'(8'h40 + t), 8'h54});
		for (int t = 0; t < 5; t++)
			fetch({8'(8'h40 + t), 8'h58});

		// Responses under back-pressure
		stall_mode = 1'b1;
		repeat (40) fetch(16'($random(seed)) & 16'h073f);
		stall_mode = 1'b0;

		// A resident line misses again after a flush
		fetch(16'h2a60);
		fetch(16'h2a64);
		flush_lines();
		fetch(16'h2a68);

		// Random fetches over eight tags and four sets
		repeat (400) fetch(16'($random(seed)) & 16'h073f);

		repeat (4) @(negedge clk);
		$display("Done after %0d responses: %0d value errors, %0d protocol errors",
			rsp_count, value_errs, proto_errs + stim_errs);
		if (value_errs + proto_errs + stim_errs == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// rsp_ready toggles after random stretches of 0 to 7 cycles in stall mode
	initial
	begin
		int stretch;
		rsp_ready = 1'b1;
		stretch = 0;
		forever
		begin
			@(negedge clk);
			if (!stall_mode)
				rsp_ready = 1'b1;
			else if (stretch > 0)
				stretch--;
			else
			begin
				rsp_ready = ~rsp_ready;
				stretch = $random(seed) & 7;
			end
		end
	end

	// ==============================
	// Memory model
	// ==============================

	// Accepts a line request after 0 to 3 cycles, then sends four beats with gaps
	initial
	begin
		int gap;
		logic [15:0] line;
		mem_req_ready = 1'b0;
		mem_rsp_valid = 1'b0;
		mem_rsp_data = 32'h0;
		forever
		begin
			@(negedge clk);
			if (mem_req_valid)
			begin
				gap = $random(seed) & 3;
				repeat (gap) @(negedge clk);
				line = mem_req.line_addr;
				mem_req_ready = 1'b1;
				@(negedge clk);
				mem_req_ready = 1'b0;
				for (int b = 0; b < 4; b++)
				begin
					gap = $random(seed) & 1;
					repeat (gap) @(negedge clk);
					mem_rsp_valid = 1'b1;
					mem_rsp_data = expected_word(line + 16'(b * 4));
					do
						@(posedge clk);
					while (!mem_rsp_ready);
					@(negedge clk);
					mem_rsp_valid = 1'b0;
				end
			end
		end
	end

	// ==============================
	// Compare
	// ==============================

	always @(posedge clk)
	begin
		edge_count++;
		if (arst_n)
		begin
			if (req_valid && req_ready)
			begin
				accept_edge = edge_count;
				mem_reqs = 0;
			end
			if (mem_req_valid && mem_req_ready)
			begin
				mem_reqs++;
				assert (!exp_hit)
				else
				begin
					proto_errs++;
					$display("Memory request issued although fetch %h should hit", exp_addr);
				end
				assert (mem_req.line_addr == {exp_addr[15:4], 4'h0})
				else
				begin
					value_errs++;
					$display("[FAIL] mem_req.line_addr = %h, expected %h",
						mem_req.line_addr, {exp_addr[15:4], 4'h0});
				end
			end
			if (rsp_valid)
			begin
				assert (!req_ready)
				else
				begin
					proto_errs++;
					$display("req_ready high while a response is pending");
				end
				if (!rsp_seen)
				begin
					// rsp_valid rises after the second edge, so it is seen on the third
					rsp_seen = 1'b1;
					if (exp_hit)
					begin
						assert (edge_count - accept_edge == 3)
						else
						begin
							proto_errs++;
							$display("Hit on %h answered %0d cycles after acceptance, not 2",
								exp_addr, edge_count - accept_edge - 1);
						end
					end
				end
				else
				begin
					assert (rsp == held_rsp)
					else
					begin
						value_errs++;
						$display("[FAIL] rsp = %h while stalled, held %h", rsp, held_rsp);
					end
				end
				held_rsp = rsp;
				if (rsp_ready)
				begin
					assert (rsp.data == exp_word)
					else
					begin
						value_errs++;
						$display("[FAIL] rsp.data = %h, expected %h", rsp.data, exp_word);
					end
					assert (rsp.addr.raw == exp_addr)
					else
					begin
						value_errs++;
						$display("[FAIL] rsp.addr = %h, expected %h", rsp.addr.raw, exp_addr);
					end
					assert (mem_reqs == (exp_hit ? 0 : 1))
					else
					begin
						proto_errs++;
						$display("Fetch %h should %s but made %0d memory requests",
							exp_addr, exp_hit ? "hit" : "miss", mem_reqs);
					end
					rsp_seen = 1'b0;
					rsp_count++;
				end
			end
			else
			begin
				assert (!rsp_seen)
				else
				begin
					proto_errs++;
					$display("rsp_valid dropped before the response was taken");
				end
				rsp_seen = 1'b0;
			end
		end
	end

	// Ends a hung run
	always @(posedge clk)
	begin
		cycle++;
		if (cycle >= max_cycles)
		begin
			$display("Timeout after %0d cycles with fetch %h still open", cycle, exp_addr);
			$display("** FAIL **");
			$finish;
		end
	end

endmodule

//--- logic/icache_top.sv
// ==============================
// Instruction cache top level
// 4-way set associative cache front end with line refill
// ==============================

`timescale 1ns/10ps

module icache_top #(
	parameter int num_sets = icache_pkg::num_sets,
	parameter int num_ways = icache_pkg::num_ways,
	parameter int words_per_line = icache_pkg::words_per_line
) (
	input logic clk,
	input logic arst_n,
	input logic flush,
	input logic req_valid,
	output logic req_ready,
	input icache_pkg::icache_addr_u req_addr,
	output logic rsp_valid,
	input logic rsp_ready,
	output icache_pkg::fetch_rsp_t rsp,
	output logic mem_req_valid,
	input logic mem_req_ready,
	output icache_pkg::mem_req_t mem_req,
	input logic mem_rsp_valid,
	output logic mem_rsp_ready,
	input logic [icache_pkg::word_w-1:0] mem_rsp_data
);

	localparam int index_w = $clog2(num_sets);
	localparam int way_w = $clog2(num_ways);
	localparam int word_off_w = $clog2(words_per_line);
	localparam int tag_w = icache_pkg::addr_w - index_w - word_off_w - icache_pkg::byte_off_w;

	// Fetch in flight and the set it selects
	icache_pkg::icache_addr_u cur_addr;
	logic [num_ways-1:0][tag_w-1:0] set_tags;
	logic [num_ways-1:0] set_valid;
	logic [way_w-1:0] victim_way;

	// Registered lookup result
	logic hit;
	logic [way_w-1:0] hit_way;
	logic [way_w-1:0] free_way;

	// Refill steering
	logic [way_w-1:0] fill_way;
	logic [word_off_w-1:0] data_offset;
	logic [word_off_w-1:0] beat_offset;
	logic last_beat;
	logic tag_write;
	logic data_write;
	logic [icache_pkg::word_w-1:0] rd_data;

	// ==============================
	// Control
	// ==============================

	icache_ctrl_fsm #(
		.num_ways(num_ways),
		.words_per_line(words_per_line)
	) u_ctrl (
		.clk(clk),
		.arst_n(arst_n),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_addr(req_addr),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp(rsp),
		.mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.mem_req(mem_req),
		.mem_rsp_valid(mem_rsp_valid),
		.mem_rsp_ready(mem_rsp_ready),
		.hit(hit),
		.hit_way(hit_way),
		.free_way(free_way),
		.last_beat(last_beat),
		.beat_offset(beat_offset),
		.cur_addr(cur_addr),
		.fill_way(fill_way),
		.data_offset(data_offset),
		.tag_write(tag_write),
		.data_write(data_write),
		.rd_data(rd_data)
	);

	// Every data write is one accepted memory beat
	icache_beat_counter #(
		.words_per_line(words_per_line)
	) u_beats (
		.clk(clk),
		.arst_n(arst_n),
		.beat(data_write),
		.offset(beat_offset),
		.last_beat(last_beat)
	);

	// ==============================
	// Lookup and storage
	// ==============================

	icache_tag_store #(
		.num_sets(num_sets),
		.num_ways(num_ways),
		.words_per_line(words_per_line)
	) u_tags (
		.clk(clk),
		.arst_n(arst_n),
		.flush(flush),
		.index(cur_addr.f.index),
		.set_tags(set_tags),
		.set_valid(set_valid),
		.victim_way(victim_way),
		.tag_write(tag_write),
		.fill_way(fill_way),
		.fill_tag(cur_addr.f.tag)
	);

	// The room flag is left open since free_way already carries the choice
	icache_hit_detect #(
		.num_sets(num_sets),
		.num_ways(num_ways),
		.words_per_line(words_per_line)
	) u_hit (
		.clk(clk),
		.arst_n(arst_n),
		.addr_tag(cur_addr.f.tag),
		.set_tags(set_tags),
		.set_valid(set_valid),
		.victim_way(victim_way),
		.hit(hit),
		.hit_way(hit_way),
		.has_free(),
		.free_way(free_way)
	);

	icache_data_store #(
		.num_sets(num_sets),
		.num_ways(num_ways),
		.words_per_line(words_per_line)
	) u_data (
		.clk(clk),
		.index(cur_addr.f.index),
		.way(fill_way),
		.offset(data_offset),
		.write(data_write),
		.wdata(mem_rsp_data),
		.rdata(rd_data)
	);

endmodule

//--- logic/icache_ctrl_fsm.sv
// ==============================
// Cache controller
// Accepts fetches, runs lookup and refill, holds the response
// ==============================

`timescale 1ns/10ps

module icache_ctrl_fsm #(
	parameter int num_ways = icache_pkg::num_ways,
	parameter int words_per_line = icache_pkg::words_per_line,
	localparam int way_w = $clog2(num_ways),
	localparam int word_off_w = $clog2(words_per_line)
) (
	input logic clk,
	input logic arst_n,
	input logic req_valid,
	output logic req_ready,
	input icache_pkg::icache_addr_u req_addr,
	output logic rsp_valid,
	input logic rsp_ready,
	output icache_pkg::fetch_rsp_t rsp,
	output logic mem_req_valid,
	input logic mem_req_ready,
	output icache_pkg::mem_req_t mem_req,
	input logic mem_rsp_valid,
	output logic mem_rsp_ready,
	input logic hit,
	input logic [way_w-1:0] hit_way,
	input logic [way_w-1:0] free_way,
	input logic last_beat,
	input logic [word_off_w-1:0] beat_offset,
	output icache_pkg::icache_addr_u cur_addr,
	output logic [way_w-1:0] fill_way,
	output logic [word_off_w-1:0] data_offset,
	output logic tag_write,
	output logic data_write,
	input logic [icache_pkg::word_w-1:0] rd_data
);

	icache_pkg::ctrl_state_e state_q;
	icache_pkg::ctrl_state_e state_d;

	// Address of the fetch in flight
	icache_pkg::icache_addr_u cur_q;

	// Way chosen for the current refill
	logic [way_w-1:0] fill_way_q;

	// Held response payload
	icache_pkg::fetch_rsp_t rsp_q;

	logic refilling;

	// ==============================
	// State machine
	// ==============================

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			icache_pkg::st_idle:
				if (req_valid)
					state_d = icache_pkg::st_lookup;
			// Hit detector needs this cycle to register its compare
			icache_pkg::st_lookup:
				state_d = icache_pkg::st_decide;
			icache_pkg::st_decide:
				state_d = hit ? icache_pkg::st_respond : icache_pkg::st_refill_req;
			icache_pkg::st_refill_req:
				if (mem_req_ready)
					state_d = icache_pkg::st_refill_data;
			// After the last beat the line is retried and hits
			icache_pkg::st_refill_data:
				if (mem_rsp_valid && last_beat)
					state_d = icache_pkg::st_lookup;
			icache_pkg::st_respond:
				if (rsp_ready)
					state_d = icache_pkg::st_idle;
			default:
				state_d = icache_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state_q <= icache_pkg::st_idle;
			fill_way_q <= '0;
		end
		else
		begin
			state_q <= state_d;
			// The hit detector already folded free way and round-robin victim together
			if (state_q == icache_pkg::st_decide && !hit)
				fill_way_q <= free_way;
		end
	end

	// Address and response payload carry no reset
	always_ff @(posedge clk)
	begin
		if (state_q == icache_pkg::st_idle && req_valid)
			cur_q <= req_addr;
		// Word is read at the hit way during decide and captured on entry to respond
		if (state_q == icache_pkg::st_decide && hit)
		begin
			rsp_q.data <= rd_data;
			rsp_q.addr <= cur_q;
		end
	end

	// ==============================
	// Outputs
	// ==============================

	assign req_ready = (state_q == icache_pkg::st_idle);
	assign rsp_valid = (state_q == icache_pkg::st_respond);
	assign rsp = rsp_q;
	assign cur_addr = cur_q;

	// Line address is the fetch address with the offset cleared
	assign mem_req_valid = (state_q == icache_pkg::st_refill_req);
	assign mem_req.line_addr = {cur_q.f.tag, cur_q.f.index, {icache_pkg::offset_w{1'b0}}};

	assign refilling = (state_q == icache_pkg::st_refill_data);
	assign mem_rsp_ready = refilling;

	// Each accepted beat writes a word; the tag goes in with the last one
	assign data_write = refilling && mem_rsp_valid;
	assign tag_write = data_write && last_beat;

	// Stores see the fill way and beat offset while refilling, else the hit way and fetch offset
	assign fill_way = refilling ? fill_way_q : hit_way;
	assign data_offset = refilling ? beat_offset : cur_q.f.word_off;

endmodule

//--- logic/icache_data_store.sv
// ==============================
// Data store
// Line words of every way and set, one word port
// ==============================

`timescale 1ns/10ps

module icache_data_store #(
	parameter int num_sets = icache_pkg::num_sets,
	parameter int num_ways = icache_pkg::num_ways,
	parameter int words_per_line = icache_pkg::words_per_line,
	localparam int index_w = $clog2(num_sets),
	localparam int way_w = $clog2(num_ways),
	localparam int word_off_w = $clog2(words_per_line)
) (
	input logic clk,
	input logic [index_w-1:0] index,
	input logic [way_w-1:0] way,
	input logic [word_off_w-1:0] offset,
	input logic write,
	input logic [icache_pkg::word_w-1:0] wdata,
	output logic [icache_pkg::word_w-1:0] rdata
);

	// Total words held across all ways
	localparam int depth = num_sets * num_ways * words_per_line;
	localparam int word_addr_w = way_w + index_w + word_off_w;

	// Word storage, written only by refills
	logic [icache_pkg::word_w-1:0] mem [depth];

	// Flat word address, way in the top bits
	logic [word_addr_w-1:0] word_addr;

	// The same address serves the refill write and the hit read
	// since the controller never does both in one cycle
	assign word_addr = {way, index, offset};

	// ==============================
	// Access
	// ==============================

	// One beat per edge during refill
	always_ff @(posedge clk)
	begin
		if (write)
		begin
			mem[word_addr] <= wdata;
		end
	end

	// Read is combinational so the controller can latch it in the same cycle
	assign rdata = mem[word_addr];

endmodule

//--- logic/icache_hit_detect.sv
// ==============================
// Hit detector
// Registered tag compare of one set, with hit way and fill way
// ==============================

`timescale 1ns/10ps

module icache_hit_detect #(
	parameter int num_sets = icache_pkg::num_sets,
	parameter int num_ways = icache_pkg::num_ways,
	parameter int words_per_line = icache_pkg::words_per_line,
	localparam int way_w = $clog2(num_ways),
	localparam int tag_w = icache_pkg::addr_w - $clog2(num_sets) - $clog2(words_per_line)
		- icache_pkg::byte_off_w
) (
	input logic clk,
	input logic arst_n,
	input logic [tag_w-1:0] addr_tag,
	input logic [num_ways-1:0][tag_w-1:0] set_tags,
	input logic [num_ways-1:0] set_valid,
	input logic [way_w-1:0] victim_way,
	output logic hit,
	output logic [way_w-1:0] hit_way,
	output logic has_free,
	output logic [way_w-1:0] free_way
);

	// Per-way match of tag and valid bit
	logic [num_ways-1:0] match;

	// Values captured on the next edge
	logic hit_d;
	logic [way_w-1:0] hit_way_d;
	logic has_free_d;
	logic [way_w-1:0] free_way_d;

	// ==============================
	// Compare
	// ==============================

	// A way hits only when its line is valid and its tag agrees
	always_comb
	begin
		for (int w = 0; w < num_ways; w++)
		begin
			match[w] = set_valid[w] && (set_tags[w] == addr_tag);
		end
	end

	assign hit_d = |match;

	// At most one way can match, but scan from the top so the lowest one wins
	always_comb
	begin
		hit_way_d = '0;
		for (int w = num_ways - 1; w >= 0; w--)
		begin
			if (match[w])
			begin
				hit_way_d = way_w'(w);
			end
		end
	end

	// ==============================
	// Fill way choice
	// ==============================

	// Any invalid way means the set still has room
	assign has_free_d = ~&set_valid;

	// Lowest invalid way first; a full set falls back to the round-robin victim
	always_comb
	begin
		free_way_d = victim_way;
		for (int w = num_ways - 1; w >= 0; w--)
		begin
			if (!set_valid[w])
			begin
				free_way_d = way_w'(w);
			end
		end
	end

	// Results are valid one edge after the set was presented
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hit <= 1'b0;
			hit_way <= '0;
			has_free <= 1'b0;
			free_way <= '0;
		end
		else
		begin
			hit <= hit_d;
			hit_way <= hit_way_d;
			has_free <= has_free_d;
			free_way <= free_way_d;
		end
	end

endmodule

//--- logic/icache_tag_store.sv
// ==============================
// Tag store
// Tag and valid arrays per way, round-robin victim pointer per set
// ==============================

`timescale 1ns/10ps

module icache_tag_store #(
	parameter int num_sets = icache_pkg::num_sets,
	parameter int num_ways = icache_pkg::num_ways,
	parameter int words_per_line = icache_pkg::words_per_line,
	localparam int index_w = $clog2(num_sets),
	localparam int way_w = $clog2(num_ways),
	localparam int tag_w = icache_pkg::addr_w - index_w - $clog2(words_per_line)
		- icache_pkg::byte_off_w
) (
	input logic clk,
	input logic arst_n,
	input logic flush,
	input logic [index_w-1:0] index,
	output logic [num_ways-1:0][tag_w-1:0] set_tags,
	output logic [num_ways-1:0] set_valid,
	output logic [way_w-1:0] victim_way,
	input logic tag_write,
	input logic [way_w-1:0] fill_way,
	input logic [tag_w-1:0] fill_tag
);

	// Tag memory, meaningful only where the matching valid bit is set
	logic [tag_w-1:0] tag_mem [num_ways][num_sets];

	// One valid bit per way and set
	logic [num_ways-1:0][num_sets-1:0] valid_q;

	// Next way to replace in each set
	logic [num_sets-1:0][way_w-1:0] rr_q;

	// ==============================
	// Writes
	// ==============================

	// The refill tag lands in the way picked by the controller
	always_ff @(posedge clk)
	begin
		if (tag_write)
		begin
			tag_mem[fill_way][index] <= fill_tag;
		end
	end

	// Flush wipes every line at once; otherwise a refill marks its line valid
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			valid_q <= '0;
		end
		else if (flush)
		begin
			valid_q <= '0;
		end
		else if (tag_write)
		begin
			valid_q[fill_way][index] <= 1'b1;
		end
	end

	// The pointer moves one past the way just filled, wrapping at the last way
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rr_q <= '0;
		end
		else if (tag_write)
		begin
			rr_q[index] <= way_w'(fill_way + 1'b1);
		end
	end

	// ==============================
	// Set read
	// ==============================

	// Present the whole indexed set without a clock
	always_comb
	begin
		for (int w = 0; w < num_ways; w++)
		begin
			set_tags[w] = tag_mem[w][index];
			set_valid[w] = valid_q[w][index];
		end
	end

	assign victim_way = rr_q[index];

endmodule

//--- logic/icache_beat_counter.sv
// ==============================
// Refill beat counter
// Word offset of each memory beat and the last beat of a line
// ==============================

`timescale 1ns/10ps

module icache_beat_counter #(
	parameter int words_per_line = icache_pkg::words_per_line,
	localparam int word_off_w = $clog2(words_per_line)
) (
	input logic clk,
	input logic arst_n,
	input logic beat,
	output logic [word_off_w-1:0] offset,
	output logic last_beat
);

	// Number of beats already taken in this line
	logic [word_off_w-1:0] count_q;

	// Beats arrive in word order, so the count is the word offset
	assign offset = count_q;
	assign last_beat = (count_q == word_off_w'(words_per_line - 1));

	// Return to zero after the last beat so the next refill starts at word 0
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			count_q <= '0;
		end
		else if (beat)
		begin
			if (last_beat)
				count_q <= '0;
			else
				count_q <= count_q + 1'b1;
		end
	end

endmodule

//--- logic/icache_pkg.sv
// ==============================
// Instruction cache package
// Geometry, the fetch address view, port payloads and controller states
// ==============================

package icache_pkg;

	// ==============================
	// Geometry
	// ==============================

	// One data word and one fetch address
	localparam int word_w = 32;
	localparam int addr_w = 16;

	// Four ways of sixteen sets, four words to a line
	localparam int num_sets = 16;
	localparam int num_ways = 4;
	localparam int words_per_line = 4;

	// Derived field widths
	localparam int index_w = $clog2(num_sets);
	localparam int way_w = $clog2(num_ways);
	localparam int word_off_w = $clog2(words_per_line);
	localparam int byte_off_w = $clog2(word_w / 8);
	localparam int offset_w = word_off_w + byte_off_w;
	localparam int tag_w = addr_w - index_w - offset_w;

	// ==============================
	// Address views
	// ==============================

	// Fields of a byte address, most significant first
	typedef struct packed {
		logic [tag_w-1:0] tag;
		logic [index_w-1:0] index;
		logic [word_off_w-1:0] word_off;
		logic [byte_off_w-1:0] byte_off;
	} icache_addr_fields;

	// The same address word, seen raw or split into fields
	typedef union packed {
		logic [addr_w-1:0] raw;
		icache_addr_fields f;
	} icache_addr_u;

	// ==============================
	// Port payloads
	// ==============================

	// Word returned to the core, with the address it belongs to
	typedef struct packed {
		logic [word_w-1:0] data;
		icache_addr_u addr;
	} fetch_rsp_t;

	// Line refill request, offset bits always zero
	typedef struct packed {
		logic [addr_w-1:0] line_addr;
	} mem_req_t;

	// Controller states
	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_decide,
		st_refill_req,
		st_refill_data,
		st_respond
	} ctrl_state_e;

endpackage
